//--- all.f
+incdir+.
obj_pkg.sv
obj_draw_if.sv
obj_zoom_calc.sv
obj_tile_store.sv
obj_row_shifter.sv
obj_draw_ctrl.sv
obj_drawer.sv
tb_obj_drawer.sv

//--- obj_config.svh
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// tile geometry
`define OBJ_TILE_DIM 16

// zoom attribute of zero gives a step of one full source pixel
`define OBJ_ZOOM_ONE 256

// tile words per sprite for each packing
`define OBJ_BURST_4BPP 16
`define OBJ_BURST_6BPP 32

// data path widths
`define OBJ_WORD_BITS 64
`define OBJ_PIX_PER_WORD 4

// framebuffer words per output row, one extra word for the sub-word shift
`define OBJ_ROW_WORDS 5

// pixel slots in a shifted row
`define OBJ_ROW_SPAN 20

`endif

//--- obj_draw_ctrl.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_draw_ctrl import obj_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  coord_t      x,
    input  coord_t      y,
    input  zoom_t       x_zoom,
    input  zoom_t       y_zoom,
    input  logic        flip_x,
    input  logic        flip_y,
    input  color_t      color,
    input  logic        bpp6,
    input  logic        zoom_ready,
    input  logic        load_done,
    input  logic        draw_done,
    output logic        zoom_start,
    output zoom_delta_t zoom_dx,
    output zoom_delta_t zoom_dy,
    output logic        load_ready,
    output logic        shifter_reset,
    output logic        busy,
    output logic        done,
    obj_draw_if.ctrl    draw
);

    draw_state_t state;
    logic        accept;

    assign accept = start && (state == IDLE);

    // window closes as soon as the final word is in
    assign load_ready = (state == LOAD) && !load_done;

    always_ff @(posedge clk) begin
        if (accept) begin
            draw.x      <= x;
            draw.y      <= y;
            draw.flip_x <= flip_x;
            draw.flip_y <= flip_y;
            draw.color  <= color;
            draw.bpp6   <= bpp6;
            zoom_dx     <= zoom_delta_t'(`OBJ_ZOOM_ONE) - {1'b0, x_zoom};
            zoom_dy     <= zoom_delta_t'(`OBJ_ZOOM_ONE) - {1'b0, y_zoom};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            busy          <= 1'b0;
            done          <= 1'b0;
            zoom_start    <= 1'b0;
            shifter_reset <= 1'b1;
        end else begin
            done          <= 1'b0;
            zoom_start    <= 1'b0;
            shifter_reset <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state         <= ZOOM;
                        busy          <= 1'b1;
                        zoom_start    <= 1'b1;
                        shifter_reset <= 1'b1;
                    end
                end
                // ready still shows the previous sprite while zoom_start is out
                ZOOM: begin
                    if (zoom_ready && !zoom_start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (load_done) begin
                        state <= DRAW;
                    end
                end
                DRAW: begin
                    if (draw_done) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a start during a sprite must leave its attributes alone
    assert property (@(posedge clk) disable iff (reset)
        start && busy |=> $stable(draw.x) && $stable(draw.y) && $stable(zoom_dx)
            && $stable(zoom_dy));

endmodule

//--- obj_draw_if.sv
`timescale 1ns/1ps

interface obj_draw_if import obj_pkg::*; ();

    // latched sprite attributes
    coord_t      x;
    coord_t      y;
    logic        flip_x;
    logic        flip_y;
    color_t      color;
    logic        bpp6;

    // zoom results, driven by the two calculators at the top
    valid_mask_t row_valid;
    idx_list_t   row_index;
    valid_mask_t col_valid;
    idx_list_t   col_index;

    modport ctrl (
        output x, y, flip_x, flip_y, color, bpp6,
        output row_valid, row_index, col_valid, col_index
    );

    modport shifter (
        input x, y, flip_x, flip_y, color, bpp6,
        input row_valid, row_index, col_valid, col_index
    );

endinterface

//--- obj_drawer.sv
`timescale 1ns/1ps

module obj_drawer import obj_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  coord_t     x,
    input  coord_t     y,
    input  zoom_t      x_zoom,
    input  zoom_t      y_zoom,
    input  logic       flip_x,
    input  logic       flip_y,
    input  color_t     color,
    input  logic       bpp6,
    input  logic       tile_valid,
    input  tile_word_t tile_data,
    input  logic       out_read,
    output logic       busy,
    output logic       load_ready,
    output logic       out_ready,
    output fb_word_t   out_data,
    output fb_be_t     out_be,
    output fb_addr_t   out_addr,
    output logic       done
);

    obj_draw_if draw_bus ();

    logic        zoom_start;
    logic        zoom_ready;
    zoom_delta_t zoom_dx;
    zoom_delta_t zoom_dy;
    logic        load_done;
    logic        draw_done;
    logic        shifter_reset;
    logic [3:0]  row_sel;
    tile_row_t   row_pixels;

    obj_draw_ctrl ctrl_inst (
        .clk, .reset, .start,
        .x, .y, .x_zoom, .y_zoom, .flip_x, .flip_y, .color, .bpp6,
        .zoom_ready, .load_done, .draw_done,
        .zoom_start, .zoom_dx, .zoom_dy,
        .load_ready, .shifter_reset, .busy, .done,
        .draw(draw_bus.ctrl)
    );

    // both axes start together, so the row side's ready stands for both
    obj_zoom_calc row_calc (
        .clk, .reset,
        .start(zoom_start), .delta(zoom_dy), .ready(zoom_ready),
        .valid(draw_bus.row_valid), .indices(draw_bus.row_index), .count()
    );

    obj_zoom_calc col_calc (
        .clk, .reset,
        .start(zoom_start), .delta(zoom_dx), .ready(),
        .valid(draw_bus.col_valid), .indices(draw_bus.col_index), .count()
    );

    obj_tile_store store_inst (
        .clk, .reset,
        .bpp6(draw_bus.bpp6),
        .tile_valid, .tile_data, .load_ready, .load_done,
        .row_sel, .row_pixels
    );

    obj_row_shifter shifter_inst (
        .clk, .shifter_reset, .load_done,
        .draw(draw_bus.shifter),
        .row_sel, .row_pixels,
        .out_read, .out_ready, .out_data, .out_be, .out_addr, .draw_done
    );

endmodule

//--- obj_pkg.sv
`include "obj_config.svh"

package obj_pkg;

    // screen position
    typedef logic [11:0] coord_t;

    // zoom attribute and accumulator step
    typedef logic [7:0] zoom_t;
    typedef logic [8:0] zoom_delta_t;

    typedef logic [5:0] pixel_t;
    typedef logic [7:0] color_t;

    typedef logic [`OBJ_WORD_BITS-1:0] tile_word_t;
    typedef logic [`OBJ_WORD_BITS-1:0] fb_word_t;
    typedef logic [`OBJ_WORD_BITS/8-1:0] fb_be_t;

    // {y[7:0], x[8:2]} in framebuffer words
    typedef logic [14:0] fb_addr_t;

    // zoom results, one entry per surviving source row or column
    typedef logic [`OBJ_TILE_DIM-1:0][3:0] idx_list_t;
    typedef logic [`OBJ_TILE_DIM-1:0] valid_mask_t;

    // one tile row, element 0 is the leftmost pixel
    typedef pixel_t [`OBJ_TILE_DIM-1:0] tile_row_t;

    typedef enum logic [1:0] {
        IDLE,
        ZOOM,
        LOAD,
        DRAW
    } draw_state_t;

endpackage

//--- obj_row_shifter.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_row_shifter import obj_pkg::*; (
    input  logic        clk,
    input  logic        shifter_reset,
    input  logic        load_done,
    obj_draw_if.shifter draw,
    output logic [3:0]  row_sel,
    input  tile_row_t   row_pixels,
    input  logic        out_read,
    output logic        out_ready,
    output fb_word_t    out_data,
    output fb_be_t      out_be,
    output fb_addr_t    out_addr,
    output logic        draw_done
);

    pixel_t     row_data [`OBJ_ROW_SPAN];
    pixel_t     placed [`OBJ_ROW_SPAN];
    logic [3:0] row;
    logic [2:0] col;
    logic       active;
    logic       last_word;
    logic [3:0] next_row;
    logic [3:0] src_row;
    logic       row_end;
    logic       is_last;

    // row 0 is prepared on load_done, later rows while the fifth word goes out
    assign next_row = active ? row + 4'd1 : 4'd0;
    assign src_row  = draw.row_index[next_row];
    assign row_sel  = draw.flip_y ? ~src_row : src_row;

    assign row_end = col == 3'(`OBJ_ROW_WORDS - 1);
    assign is_last = row_end && (row == 4'd15 || !draw.row_valid[row + 4'd1]);

    always_comb begin
        logic [3:0] ci;
        ci = '0;
        for (int i = 0; i < `OBJ_ROW_SPAN; i++) begin
            placed[i] = '0;
        end
        if (draw.row_valid[next_row]) begin
            for (int i = 0; i < `OBJ_TILE_DIM; i++) begin
                ci = draw.flip_x ? ~draw.col_index[i] : draw.col_index[i];
                if (draw.col_valid[i]) begin
                    placed[i + int'(draw.x[1:0])] = row_pixels[ci];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shifter_reset) begin
            active    <= 1'b0;
            out_ready <= 1'b0;
            draw_done <= 1'b0;
            last_word <= 1'b0;
            row       <= '0;
            col       <= '0;
        end else begin
            draw_done <= 1'b0;
            if (load_done) begin
                // nothing survived the vertical zoom
                if (draw.row_valid[0]) begin
                    row_data <= placed;
                    active   <= 1'b1;
                end else begin
                    draw_done <= 1'b1;
                end
            end else if (active && (!out_ready || out_read)) begin
                if (last_word) begin
                    out_ready <= 1'b0;
                    active    <= 1'b0;
                    draw_done <= 1'b1;
                end else begin
                    out_ready <= 1'b1;
                    out_addr  <= {draw.y[7:0], draw.x[8:2]} + {4'd0, row, 4'd0, col};
                    for (int l = 0; l < `OBJ_PIX_PER_WORD; l++) begin
                        if (draw.bpp6) begin
                            out_data[16*l +: 16] <= {4'd0, draw.color[7:2], row_data[l]};
                        end else begin
                            out_data[16*l +: 16] <= {4'd0, draw.color, row_data[l][3:0]};
                        end
                        out_be[2*l +: 2] <= {2{|row_data[l]}};
                    end
                    if (row_end) begin
                        row_data  <= placed;
                        row       <= row + 4'd1;
                        col       <= '0;
                        last_word <= is_last;
                    end else begin
                        for (int i = 0; i < `OBJ_ROW_SPAN; i++) begin
                            row_data[i] <= (i < `OBJ_ROW_SPAN - `OBJ_PIX_PER_WORD)
                                ? row_data[(i + `OBJ_PIX_PER_WORD) % `OBJ_ROW_SPAN] : '0;
                        end
                        col <= col + 3'd1;
                    end
                end
            end
        end
    end

endmodule

//--- obj_tile_store.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_tile_store import obj_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       bpp6,
    input  logic       tile_valid,
    input  tile_word_t tile_data,
    input  logic       load_ready,
    output logic       load_done,
    input  logic [3:0] row_sel,
    output tile_row_t  row_pixels
);

    tile_row_t        rows [`OBJ_TILE_DIM];
    logic [4:0]       word_idx;
    logic             accept;
    logic             last_word;
    tile_row_t        dec4;
    pixel_t [7:0]     dec6;

    assign accept = tile_valid && load_ready;

    assign last_word = bpp6 ? (word_idx == 5'(`OBJ_BURST_6BPP - 1))
                            : (word_idx == 5'(`OBJ_BURST_4BPP - 1));

    // 4bpp: one nibble per pixel, low nibble first, a whole row per word
    always_comb begin
        for (int i = 0; i < `OBJ_TILE_DIM; i++) begin
            dec4[i] = {2'b00, tile_data[4*i +: 4]};
        end
    end

    // 6bpp: each 32-bit half gives four pixels, the high two bits come from
    // the third byte and the low nibble from the first two bytes
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            dec6[4*h + 0] = {tile_data[32*h + 16 +: 2], tile_data[32*h + 8 +: 4]};
            dec6[4*h + 1] = {tile_data[32*h + 18 +: 2], tile_data[32*h + 12 +: 4]};
            dec6[4*h + 2] = {tile_data[32*h + 20 +: 2], tile_data[32*h + 0 +: 4]};
            dec6[4*h + 3] = {tile_data[32*h + 22 +: 2], tile_data[32*h + 4 +: 4]};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (!bpp6) begin
                rows[word_idx[3:0]] <= dec4;
            end else if (word_idx[0]) begin
                rows[word_idx[4:1]][15:8] <= dec6;
            end else begin
                rows[word_idx[4:1]][7:0] <= dec6;
            end
        end
    end

    // counter wraps on the final word so each sprite starts from zero
    always_ff @(posedge clk) begin
        if (reset) begin
            word_idx  <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= accept && last_word;
            if (accept) begin
                word_idx <= last_word ? 5'd0 : word_idx + 5'd1;
            end
        end
    end

    assign row_pixels = rows[row_sel];

endmodule

//--- obj_zoom_calc.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_zoom_calc import obj_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  zoom_delta_t delta,
    output logic        ready,
    output valid_mask_t valid,
    output idx_list_t   indices,
    output logic [4:0]  count
);

    zoom_delta_t accum;
    zoom_delta_t next_accum;
    logic [3:0]  index;
    logic        running;
    logic        hit;

    assign next_accum = accum + delta;

    // a source index survives when the accumulator crosses a pixel boundary
    assign hit = next_accum[8] != accum[8];

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            ready   <= 1'b0;
            index   <= '0;
            count   <= '0;
            valid   <= '0;
        end else if (start) begin
            running <= 1'b1;
            ready   <= 1'b0;
            index   <= '0;
            count   <= '0;
            valid   <= '0;
        end else if (running) begin
            index <= index + 4'd1;
            if (hit) begin
                valid[count[3:0]] <= 1'b1;
                count             <= count + 5'd1;
            end
            if (index == 4'(`OBJ_TILE_DIM - 1)) begin
                running <= 1'b0;
                ready   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            accum <= '0;
        end else if (running) begin
            accum <= next_accum;
            if (hit) begin
                indices[count[3:0]] <= index;
            end
        end
    end

    // one start, then sixteen steps and the list is complete
    assert property (@(posedge clk) disable iff (reset)
        start |-> ##17 (ready && count <= 5'd16));

endmodule

//--- tb_obj_drawer.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module tb_obj_drawer import obj_pkg::*; ();

    localparam int NUM_SPRITES = 6;
    localparam int WATCHDOG_CYCLES = 8 + NUM_SPRITES * 200;

    logic       clk = 1'b0;
    logic       reset;
    logic       start;
    coord_t     x;
    coord_t     y;
    zoom_t      x_zoom;
    zoom_t      y_zoom;
    logic       flip_x;
    logic       flip_y;
    color_t     color;
    logic       bpp6;
    logic       tile_valid;
    tile_word_t tile_data;
    logic       out_read;
    logic       busy;
    logic       load_ready;
    logic       out_ready;
    fb_word_t   out_data;
    fb_be_t     out_be;
    fb_addr_t   out_addr;
    logic       done;

    logic [63:0] rng_state = 64'd59;
    tile_word_t  tile_words [32];
    fb_word_t    exp_data_q [$];
    fb_be_t      exp_be_q [$];
    fb_addr_t    exp_addr_q [$];
    fb_word_t    exp_data;
    fb_word_t    act_data;
    fb_be_t      exp_be;
    fb_be_t      act_be;
    fb_addr_t    exp_addr;
    fb_addr_t    act_addr;
    logic        chk_pending;
    logic        chk_missing;
    int          done_count = 0;
    int          err_count = 0;

    obj_drawer obj_drawer_inst (.*);

    always #20 clk = ~clk;

    task automatic report_error(input string msg);
        err_count++;
        $display("ERR %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 7);
        v = v ^ (v << 17);
        return v;
    endfunction

    function automatic logic [63:0] next_random();
        rng_state = xorshift64(rng_state);
        return rng_state;
    endfunction

    task automatic fill_tile();
        for (int w = 0; w < 32; w++) begin
            tile_words[w] = next_random();
        end
    endtask

    // bit i set when source index i survives the accumulator
    function automatic logic [15:0] surviving(input zoom_t zoom);
        logic [8:0]  acc;
        logic [8:0]  step;
        logic [8:0]  nxt;
        logic [15:0] mask;
        acc = '0;
        step = 9'(`OBJ_ZOOM_ONE - int'(zoom));
        mask = '0;
        for (int i = 0; i < 16; i++) begin
            nxt = acc + step;
            mask[i] = nxt[8] ^ acc[8];
            acc = nxt;
        end
        return mask;
    endfunction

    task automatic build_expected(input coord_t sx, input coord_t sy, input zoom_t xz,
                                  input zoom_t yz, input logic fx, input logic fy,
                                  input color_t col, input logic b6);
        pixel_t      pix [16][16];
        pixel_t      slot [`OBJ_ROW_SPAN];
        logic [15:0] rmask;
        logic [15:0] cmask;
        logic [31:0] d;
        logic [15:0] lane;
        fb_word_t    data;
        fb_be_t      be;
        int          out_row;
        int          n;
        int          src;
        rmask = surviving(yz);
        cmask = surviving(xz);
        for (int w = 0; w < 32; w++) begin
            if (!b6 && w < 16) begin
                for (int i = 0; i < 16; i++) begin
                    pix[w][i] = {2'b00, tile_words[w][4*i +: 4]};
                end
            end else if (b6) begin
                for (int h = 0; h < 2; h++) begin
                    d = tile_words[w][32*h +: 32];
                    pix[w/2][8*(w%2) + 4*h + 0] = {d[17:16], d[11:8]};
                    pix[w/2][8*(w%2) + 4*h + 1] = {d[19:18], d[15:12]};
                    pix[w/2][8*(w%2) + 4*h + 2] = {d[21:20], d[3:0]};
                    pix[w/2][8*(w%2) + 4*h + 3] = {d[23:22], d[7:4]};
                end
            end
        end
        out_row = 0;
        for (int r = 0; r < 16; r++) begin
            if (rmask[r]) begin
                src = fy ? 15 - r : r;
                for (int s = 0; s < `OBJ_ROW_SPAN; s++) begin
                    slot[s] = '0;
                end
                n = 0;
                for (int c = 0; c < 16; c++) begin
                    if (cmask[c]) begin
                        slot[n + int'(sx[1:0])] = pix[src][fx ? 15 - c : c];
                        n++;
                    end
                end
                for (int w = 0; w < `OBJ_ROW_WORDS; w++) begin
                    for (int l = 0; l < `OBJ_PIX_PER_WORD; l++) begin
                        if (b6) begin
                            lane = ((16'(col) >> 2) << 6) | 16'(slot[4*w + l]);
                        end else begin
                            lane = (16'(col) << 4) | 16'(slot[4*w + l]);
                        end
                        data[16*l +: 16] = lane;
                        be[2*l +: 2] = {2{slot[4*w + l] != 0}};
                    end
                    exp_data_q.push_back(data);
                    exp_be_q.push_back(be);
                    exp_addr_q.push_back(15'({sy[7:0], sx[8:2]} + out_row * 128 + w));
                end
                out_row++;
            end
        end
    endtask

    task automatic draw_sprite(input coord_t sx, input coord_t sy, input zoom_t xz,
                               input zoom_t yz, input logic fx, input logic fy,
                               input color_t col, input logic b6, input logic gaps,
                               input int stall, input int exp_words);
        int   words;
        int   sent;
        int   reads;
        int   stall_left;
        int   done_before;
        logic go;
        build_expected(sx, sy, xz, yz, fx, fy, col, b6);
        words = b6 ? `OBJ_BURST_6BPP : `OBJ_BURST_4BPP;
        done_before = done_count;
        start = 1'b1;
        x = sx;
        y = sy;
        x_zoom = xz;
        y_zoom = yz;
        flip_x = fx;
        flip_y = fy;
        color = col;
        bpp6 = b6;
        sent = 0;
        // strobes before the load window opens are dropped by the DUT
        while (sent < words) begin
            @(posedge clk);
            #1;
            start = 1'b0;
            go = gaps ? ((next_random() & 64'd3) != 0) : 1'b1;
            tile_valid = go;
            tile_data = go ? tile_words[sent] : next_random();
            if (go && load_ready) begin
                sent++;
            end
        end
        @(posedge clk);
        #1;
        tile_valid = 1'b0;
        reads = 0;
        stall_left = stall;
        while (!done) begin
            @(posedge clk);
            #1;
            go = gaps ? ((next_random() & 64'd3) != 0) : 1'b1;
            if (stall_left > 0 && out_ready) begin
                go = 1'b0;
                stall_left--;
            end
            out_read = out_ready && go;
            if (out_read) begin
                reads++;
            end
            // a start in the middle of a sprite, with other attributes
            start = gaps && reads == 3;
            x = start ? 12'hfff : sx;
            y = start ? ~sy : sy;
            x_zoom = start ? ~xz : xz;
            y_zoom = start ? ~yz : yz;
        end
        out_read = 1'b0;
        start = 1'b0;
        @(posedge clk);
        #1;
        assert (done_count == done_before + 1)
            else report_error("done did not pulse exactly once");
        assert (reads == exp_words)
            else report_error($sformatf("%0d words read, expected %0d", reads, exp_words));
        assert (exp_data_q.size() == 0)
            else report_error($sformatf("%0d expected words never read", exp_data_q.size()));
    endtask

    // capture each consumed word with the model's next word
    always @(posedge clk) begin
        if (reset) begin
            chk_pending <= 1'b0;
            chk_missing <= 1'b0;
        end else begin
            chk_pending <= out_read && out_ready;
            if (out_read && out_ready) begin
                act_data <= out_data;
                act_be <= out_be;
                act_addr <= out_addr;
                chk_missing <= exp_data_q.size() == 0;
                if (exp_data_q.size() != 0) begin
                    exp_data <= exp_data_q.pop_front();
                    exp_be <= exp_be_q.pop_front();
                    exp_addr <= exp_addr_q.pop_front();
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && done) begin
            done_count++;
        end
    end

    assert property (@(posedge clk) disable iff (reset) chk_pending |-> !chk_missing)
        else report_error("out_read took a word the model did not expect");

    assert property (@(posedge clk) disable iff (reset)
        chk_pending |-> act_data == exp_data && act_be == exp_be && act_addr == exp_addr)
        else report_error($sformatf("got %h be %h addr %h, expected %h be %h addr %h",
            $sampled(act_data), $sampled(act_be), $sampled(act_addr),
            $sampled(exp_data), $sampled(exp_be), $sampled(exp_addr)));

    assert property (@(posedge clk) disable iff (reset) start && !busy |=> busy)
        else report_error("busy did not rise after start");

    // zoom pass of 17 cycles, then one cycle into the load state
    assert property (@(posedge clk) disable iff (reset)
        start && !busy |=> !load_ready [*18] ##1 load_ready)
        else report_error("load window did not open after the zoom pass");

    assert property (@(posedge clk) disable iff (reset)
        out_ready && !out_read |=> out_ready && $stable(out_data) && $stable(out_be)
            && $stable(out_addr))
        else report_error("output word changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        done |-> !busy && !load_ready && !out_ready)
        else report_error("drawer not idle when done");

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else report_error("done longer than one cycle");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: drawer did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1);
    end

    initial begin
        reset = 1'b1;
        start = 1'b0;
        x = '0;
        y = '0;
        x_zoom = '0;
        y_zoom = '0;
        flip_x = 1'b0;
        flip_y = 1'b0;
        color = '0;
        bpp6 = 1'b0;
        tile_valid = 1'b0;
        tile_data = '0;
        out_read = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!busy && !load_ready && !out_ready && !done)
            else report_error("outputs not idle after reset");
        fill_tile();
        draw_sprite(12'h000, 12'h035, 8'h00, 8'h00, 1'b0, 1'b0, 8'h5a, 1'b0, 1'b0, 0, 80);
        // same tile, mirrored both ways
        draw_sprite(12'h000, 12'h035, 8'h00, 8'h00, 1'b1, 1'b1, 8'h5a, 1'b0, 1'b0, 0, 80);
        fill_tile();
        draw_sprite(12'h104, 12'h0c2, 8'h00, 8'h00, 1'b0, 1'b0, 8'hb7, 1'b1, 1'b0, 0, 80);
        fill_tile();
        draw_sprite(12'h0a6, 12'h050, 8'h80, 8'h80, 1'b0, 1'b0, 8'h3c, 1'b0, 1'b0, 0, 40);
        fill_tile();
        draw_sprite(12'h1f3, 12'h0e7, 8'h30, 8'h00, 1'b1, 1'b0, 8'hd1, 1'b1, 1'b1, 0, 80);
        fill_tile();
        draw_sprite(12'h0ff, 12'h1ab, 8'h00, 8'h00, 1'b0, 1'b1, 8'h96, 1'b0, 1'b1, 25, 80);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
